/* include/motion_defs.svh */
// Motion core widths, sizes, reset defaults and version constants
`ifndef MOTION_DEFS_SVH
`define MOTION_DEFS_SVH

// Host interface
`define WORD_BITS 64

// Axis and DDA geometry
`define NUM_MOTORS 2
`define DDA_BITS 64
`define MOVE_DURATION_BITS 32

// Move store depth
`define BUFFER_SIZE 2

// DDA tick divisor after reset
`define DEFAULT_CLOCK_DIVISOR 32

// Reported API version bytes
`define VERSION_PATCH 8'h00
`define VERSION_MINOR 8'h01
`define VERSION_MAJOR 8'h00
`define VERSION_DEVEL 8'h01

`endif

/* logic/motion_pkg.sv */
// Motion core types for host commands, host words and buffered moves
package motion_pkg;

  `include "motion_defs.svh"

  // Host command codes, first byte of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_MOTOR_BRAKE      = 8'h0b,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_CHANNEL_INFO     = 8'hfd,
    CMD_API_VERSION      = 8'hfe
  } cmd_t;

  typedef struct packed {
    cmd_t        cmd;
    logic [7:0]  channel;
    logic [47:0] payload;
  } host_header_t;

  // Same word seen as a command header or as raw move data
  typedef union packed {
    host_header_t            header;
    logic [`WORD_BITS-1:0]   data;
  } host_word_u;

  typedef struct packed {
    logic [`DDA_BITS-1:0] increment;
    logic [`DDA_BITS-1:0] incr_incr;
  } axis_params_t;

  typedef struct packed {
    logic [`NUM_MOTORS-1:0]         dir;
    logic [`MOVE_DURATION_BITS-1:0] duration;
    axis_params_t [`NUM_MOTORS-1:0] axis;
  } move_entry_t;

  typedef struct packed {
    logic        push;
    move_entry_t entry;
  } move_push_t;

endpackage

/* logic/command_decoder.sv */
// Host word decoder for configuration, status replies and coordinated moves
`timescale 1ns/1ps
`include "motion_defs.svh"

module command_decoder
  import motion_pkg::*;
(
  input  logic                   CLK,
  input  logic                   resetn,
  input  host_word_u             word_data,
  input  logic                   word_received,
  output logic [`WORD_BITS-1:0]  word_send_data,
  output move_push_t             move_push,
  output logic [`NUM_MOTORS-1:0] enable,
  output logic [`NUM_MOTORS-1:0] brake,
  output logic [7:0]             clock_divisor
);

  // Header, duration, then two words per axis
  localparam int LAST_WORD = 2 * `NUM_MOTORS + 1;

  logic                  word_received_q;
  logic                  word_rise;
  logic [7:0]            message_header;
  logic [7:0]            word_count;
  logic                  in_move;
  logic                  push_q;
  move_entry_t           staged;
  logic [`WORD_BITS-1:0] reply;

  assign word_rise = word_received & ~word_received_q;
  assign in_move   = (message_header == CMD_COORDINATED_STEP);

  assign move_push.push  = push_q;
  assign move_push.entry = staged;

  // Reply depends only on the word being received
  always_comb begin
    reply = '0;
    if (!in_move) begin
      case (word_data.header.cmd)
        CMD_API_VERSION: begin
          reply[31:0] = {`VERSION_DEVEL, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
        end
        CMD_CHANNEL_INFO: begin
          reply[31:0] = {8'(`MOVE_DURATION_BITS), 8'(`DDA_BITS), 8'd0, 8'(`NUM_MOTORS)};
        end
        default: reply = '0;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      word_send_data  <= '0;
      message_header  <= 8'h00;
      word_count      <= 8'd0;
      push_q          <= 1'b0;
      enable          <= '0;
      brake           <= '0;
      clock_divisor   <= 8'(`DEFAULT_CLOCK_DIVISOR);
    end else begin
      word_received_q <= word_received;
      push_q          <= 1'b0;
      if (word_rise) begin
        word_send_data <= reply;
        if (!in_move) begin
          // New message
          message_header <= word_data.header.cmd;
          word_count     <= 8'd1;
          case (word_data.header.cmd)
            CMD_MOTOR_ENABLE: enable <= word_data.header.payload[`NUM_MOTORS-1:0];
            CMD_MOTOR_BRAKE:  brake <= word_data.header.payload[`NUM_MOTORS-1:0];
            CMD_CLK_DIVISOR:  clock_divisor <= word_data.header.payload[7:0];
            default: ;
          endcase
        end else if (word_count == 8'(LAST_WORD)) begin
          // Final axis word completes the move
          push_q         <= 1'b1;
          message_header <= 8'h00;
          word_count     <= 8'd0;
        end else begin
          word_count <= word_count + 8'd1;
        end
      end
    end
  end

  // Move fields collected word by word
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!in_move) begin
        if (word_data.header.cmd == CMD_COORDINATED_STEP) begin
          staged.dir <= word_data.header.payload[`NUM_MOTORS-1:0];
        end
      end else begin
        if (word_count == 8'd1) begin
          staged.duration <= word_data.data[`MOVE_DURATION_BITS-1:0];
        end
        for (int i = 0; i < `NUM_MOTORS; i++) begin
          if (word_count == 8'(2 * i + 2)) begin
            staged.axis[i].increment <= word_data.data;
          end
          if (word_count == 8'(2 * i + 3)) begin
            staged.axis[i].incr_incr <= word_data.data;
          end
        end
      end
    end
  end

endmodule

/* logic/move_buffer.sv */
// Two-slot move store with toggle handshake toward the DDA sequencer
`timescale 1ns/1ps
`include "motion_defs.svh"

module move_buffer
  import motion_pkg::*;
(
  input  logic                    CLK,
  input  logic                    resetn,
  input  move_push_t              move_push,
  input  logic                    read_slot,
  input  logic [`BUFFER_SIZE-1:0] consumed,
  output logic [`BUFFER_SIZE-1:0] ready,
  output move_entry_t             read_entry,
  output logic                    buffer_dtr
);

  move_entry_t             slots [`BUFFER_SIZE];
  logic                    write_slot;
  logic [`BUFFER_SIZE-1:0] full;
  logic                    accept;

  // Slot holds a move the sequencer has not retired yet
  assign full   = ready ^ consumed;
  assign accept = move_push.push & ~full[write_slot];

  assign buffer_dtr = ~&full;
  assign read_entry = slots[read_slot];

  always_ff @(posedge CLK) begin
    if (accept) begin
      slots[write_slot] <= move_push.entry;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      ready      <= '0;
      write_slot <= 1'b0;
    end else if (accept) begin
      ready[write_slot] <= ~ready[write_slot];
      // Wrap at the last slot
      if (write_slot == 1'(`BUFFER_SIZE - 1)) begin
        write_slot <= 1'b0;
      end else begin
        write_slot <= write_slot + 1'b1;
      end
    end
  end

endmodule

/* logic/dda_sequencer.sv */
// DDA tick divider and move FSM that loads, times and retires buffered moves
`timescale 1ns/1ps
`include "motion_defs.svh"

module dda_sequencer (
  input  logic                           CLK,
  input  logic                           resetn,
  input  logic [7:0]                     clock_divisor,
  input  logic [`BUFFER_SIZE-1:0]        ready,
  input  logic [`MOVE_DURATION_BITS-1:0] duration,
  output logic                           dda_tick,
  output logic                           loading_move,
  output logic                           executing_move,
  output logic                           move_done,
  output logic                           read_slot,
  output logic [`BUFFER_SIZE-1:0]        consumed
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_EXEC
  } state_t;

  state_t                         state;
  logic [7:0]                     div_count;
  logic [7:0]                     div_limit;
  logic [`MOVE_DURATION_BITS-1:0] tick_count;
  logic [`BUFFER_SIZE-1:0]        full;
  logic                           retire;

  // Divisor of zero behaves like one
  assign div_limit = (clock_divisor == 8'd0) ? 8'd0 : clock_divisor - 8'd1;

  assign full           = ready ^ consumed;
  assign loading_move   = (state == S_LOAD);
  assign executing_move = (state == S_EXEC);

  // Last tick of the move, or an empty move seen at load
  assign retire = (loading_move && duration == '0) ||
                  (executing_move && dda_tick && tick_count == duration - 1'b1);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_count <= 8'd0;
      dda_tick  <= 1'b0;
    end else if (div_count >= div_limit) begin
      div_count <= 8'd0;
      dda_tick  <= 1'b1;
    end else begin
      div_count <= div_count + 8'd1;
      dda_tick  <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= S_IDLE;
      tick_count <= '0;
      move_done  <= 1'b0;
      read_slot  <= 1'b0;
      consumed   <= '0;
    end else begin
      move_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (full[read_slot]) begin
            state <= S_LOAD;
          end
        end
        S_LOAD: begin
          tick_count <= '0;
          state      <= retire ? S_IDLE : S_EXEC;
        end
        S_EXEC: begin
          if (retire) begin
            state <= S_IDLE;
          end else if (dda_tick) begin
            tick_count <= tick_count + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
      if (retire) begin
        move_done           <= 1'b1;
        consumed[read_slot] <= ~consumed[read_slot];
        read_slot           <= (read_slot == 1'(`BUFFER_SIZE - 1)) ? 1'b0 : read_slot + 1'b1;
      end
    end
  end

endmodule

/* logic/dda_axis.sv */
// Per-axis DDA accumulator with second-order velocity and carry step output
`timescale 1ns/1ps
`include "motion_defs.svh"

module dda_axis
  import motion_pkg::*;
(
  input  logic         CLK,
  input  logic         resetn,
  input  logic         dda_tick,
  input  logic         loading_move,
  input  logic         executing_move,
  input  axis_params_t params,
  output logic         step
);

  logic [`DDA_BITS-1:0] accum;
  logic [`DDA_BITS-1:0] velocity;
  logic [`DDA_BITS:0]   sum;

  assign sum = {1'b0, accum} + {1'b0, velocity};

  // Step in the same cycle as the tick that overflows
  assign step = dda_tick & executing_move & sum[`DDA_BITS];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum    <= '0;
      velocity <= '0;
    end else if (loading_move) begin
      accum    <= '0;
      velocity <= params.increment;
    end else if (executing_move && dda_tick) begin
      accum    <= sum[`DDA_BITS-1:0];
      velocity <= velocity + params.incr_incr;
    end
  end

endmodule

/* logic/motion_core_top.sv */
// Motion core top with host decoder, move buffer, DDA sequencer and axis array
`timescale 1ns/1ps
`include "motion_defs.svh"

module motion_core_top
  import motion_pkg::*;
(
  input  logic                   CLK,
  input  logic                   resetn,
  input  host_word_u             word_data,
  input  logic                   word_received,
  output logic [`WORD_BITS-1:0]  word_send_data,
  output logic [`NUM_MOTORS-1:0] step,
  output logic [`NUM_MOTORS-1:0] dir,
  output logic [`NUM_MOTORS-1:0] enable,
  output logic [`NUM_MOTORS-1:0] brake,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  move_push_t              move_push;
  move_entry_t             read_entry;
  logic [7:0]              clock_divisor;
  logic [`BUFFER_SIZE-1:0] ready;
  logic [`BUFFER_SIZE-1:0] consumed;
  logic                    read_slot;
  logic                    dda_tick;
  logic                    loading_move;
  logic                    executing_move;

  // Direction only while a move runs
  assign dir = read_entry.dir & {`NUM_MOTORS{executing_move}};

  command_decoder u_decoder (
    .CLK            (CLK),
    .resetn         (resetn),
    .word_data      (word_data),
    .word_received  (word_received),
    .word_send_data (word_send_data),
    .move_push      (move_push),
    .enable         (enable),
    .brake          (brake),
    .clock_divisor  (clock_divisor)
  );

  move_buffer u_buffer (
    .CLK        (CLK),
    .resetn     (resetn),
    .move_push  (move_push),
    .read_slot  (read_slot),
    .consumed   (consumed),
    .ready      (ready),
    .read_entry (read_entry),
    .buffer_dtr (buffer_dtr)
  );

  dda_sequencer u_sequencer (
    .CLK            (CLK),
    .resetn         (resetn),
    .clock_divisor  (clock_divisor),
    .ready          (ready),
    .duration       (read_entry.duration),
    .dda_tick       (dda_tick),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done),
    .read_slot      (read_slot),
    .consumed       (consumed)
  );

  for (genvar g = 0; g < `NUM_MOTORS; g++) begin : g_axis
    dda_axis u_axis (
      .CLK            (CLK),
      .resetn         (resetn),
      .dda_tick       (dda_tick),
      .loading_move   (loading_move),
      .executing_move (executing_move),
      .params         (read_entry.axis[g]),
      .step           (step[g])
    );
  end

endmodule

/* tb/tb_motion_core.sv */
// Motion core testbench driving host words and checking replies, moves and steps
`timescale 1ns/1ps
`include "motion_defs.svh"

module tb_motion_core
  import motion_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;

  logic                   CLK;
  logic                   resetn;
  host_word_u             word_data;
  logic                   word_received;
  logic [`WORD_BITS-1:0]  word_send_data;
  logic [`NUM_MOTORS-1:0] step;
  logic [`NUM_MOTORS-1:0] dir;
  logic [`NUM_MOTORS-1:0] enable;
  logic [`NUM_MOTORS-1:0] brake;
  logic                   buffer_dtr;
  logic                   move_done;

  integer                 seed = 2914;
  int                     value_errors = 0;
  int                     pulse_errors = 0;
  int                     timeout_errors = 0;
  int                     step_count [`NUM_MOTORS] = '{default: 0};
  int                     done_count = 0;
  logic [`NUM_MOTORS-1:0] expected_dir;

  motion_core_top DUT (
    .CLK            (CLK),
    .resetn         (resetn),
    .word_data      (word_data),
    .word_received  (word_received),
    .word_send_data (word_send_data),
    .step           (step),
    .dir            (dir),
    .enable         (enable),
    .brake          (brake),
    .buffer_dtr     (buffer_dtr),
    .move_done      (move_done)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("[FAIL] %s: expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  // Pulse shapes
  assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else begin
      pulse_errors++;
      $display("move_done stayed high for more than one cycle");
    end
  assert property (@(posedge CLK) disable iff (resetn) DUT.loading_move |=> !DUT.loading_move)
    else begin
      pulse_errors++;
      $display("loading_move stayed high for more than one cycle");
    end
  assert property (@(posedge CLK) disable iff (resetn) (step != '0) |-> DUT.executing_move)
    else begin
      pulse_errors++;
      $display("A step pulse appeared while no move was executing");
    end

  // Step and move_done counting plus dir check on settled values
  always @(negedge CLK) begin
    if (!resetn) begin
      for (int i = 0; i < `NUM_MOTORS; i++) begin
        if (step[i]) step_count[i] <= step_count[i] + 1;
      end
      if (move_done) done_count <= done_count + 1;
      if (DUT.executing_move) begin
        check_value("dir", 64'(dir), 64'(expected_dir));
      end else begin
        check_value("dir", 64'(dir), 64'd0);
      end
    end
  end

  function automatic logic [63:0] make_header(input logic [7:0] cmd, input logic [47:0] payload);
    return {cmd, 8'h00, payload};
  endfunction

  // Reference model of the DDA carry rule
  function automatic int count_carries(input logic [31:0] ticks, input axis_params_t p);
    logic [`DDA_BITS:0]   sum;
    logic [`DDA_BITS-1:0] acc;
    logic [`DDA_BITS-1:0] vel;
    int                   carries;
    acc     = '0;
    vel     = p.increment;
    carries = 0;
    for (int k = 0; k < int'(ticks); k++) begin
      sum = {1'b0, acc} + {1'b0, vel};
      if (sum[`DDA_BITS]) carries++;
      acc = sum[`DDA_BITS-1:0];
      vel = vel + p.incr_incr;
    end
    return carries;
  endfunction

  task automatic send_word(input logic [63:0] word, output logic [63:0] reply);
    @(negedge CLK);
    word_data.data = word;
    word_received  = 1'b1;
    @(negedge CLK);
    @(negedge CLK);
    reply         = word_send_data;
    word_received = 1'b0;
    @(negedge CLK);
    @(negedge CLK);
  endtask

  task automatic send_move(input logic [`NUM_MOTORS-1:0] dir_bits, input logic [31:0] dur,
                           input axis_params_t [`NUM_MOTORS-1:0] axes);
    logic [63:0] reply;
    send_word(make_header(CMD_COORDINATED_STEP, 48'(dir_bits)), reply);
    send_word(64'(dur), reply);
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      send_word(axes[i].increment, reply);
      send_word(axes[i].incr_incr, reply);
    end
  endtask

  task automatic wait_dtr(input logic level, output bit ok);
    int n;
    n = 0;
    while (buffer_dtr !== level && n < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      n++;
    end
    ok = (buffer_dtr === level);
    if (!ok) begin
      timeout_errors++;
      $display("Timed out waiting for buffer_dtr to become %0b", level);
    end
  endtask

  task automatic wait_done(input int target, output bit ok);
    int n;
    n = 0;
    while (done_count < target && n < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      n++;
    end
    ok = (done_count >= target);
    if (!ok) begin
      timeout_errors++;
      $display("Timed out waiting for move_done");
    end
  endtask

  task automatic run_move(input logic [`NUM_MOTORS-1:0] dir_bits, input logic [31:0] dur,
                          input axis_params_t [`NUM_MOTORS-1:0] axes,
                          input logic [`NUM_MOTORS-1:0][31:0] expected_steps);
    int base_steps [`NUM_MOTORS];
    int base_done;
    bit ok;
    wait_dtr(1'b1, ok);
    if (!ok) return;
    expected_dir = dir_bits;
    base_done    = done_count;
    for (int i = 0; i < `NUM_MOTORS; i++) base_steps[i] = step_count[i];
    send_move(dir_bits, dur, axes);
    wait_done(base_done + 1, ok);
    if (!ok) return;
    // Window long enough for a repeated run of the same slot to show up
    for (int n = 0; n < 4 * int'(dur) + 20; n++) @(negedge CLK);
    check_value("move_done count", 64'(done_count - base_done), 64'd1);
    for (int i = 0; i < `NUM_MOTORS; i++) begin
      check_value($sformatf("step[%0d] count", i), 64'(step_count[i] - base_steps[i]),
                  64'(expected_steps[i]));
    end
  endtask

  // Third push lands on a full slot and must vanish
  task automatic fill_buffer_and_drop();
    axis_params_t [`NUM_MOTORS-1:0] axes;
    logic [31:0]                    dur;
    int                             base_done;
    bit                             ok;
    axes         = '0;
    dur          = 32'(100 + ($random(seed) & 31));
    expected_dir = `NUM_MOTORS'($random(seed));
    base_done    = done_count;
    wait_dtr(1'b1, ok);
    if (!ok) return;
    send_move(expected_dir, dur, axes);
    wait_dtr(1'b1, ok);
    if (!ok) return;
    send_move(expected_dir, dur, axes);
    wait_dtr(1'b0, ok);
    if (!ok) return;
    send_move(expected_dir, dur, axes);
    wait_done(base_done + 2, ok);
    if (!ok) return;
    // Long enough for a stored third move to finish
    for (int n = 0; n < 4 * int'(dur) + 100; n++) @(negedge CLK);
    check_value("move_done count", 64'(done_count - base_done), 64'd2);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
  endtask

  initial begin
    logic [63:0]                    reply;
    logic [`NUM_MOTORS-1:0]         pattern;
    logic [31:0]                    dur;
    axis_params_t [`NUM_MOTORS-1:0] axes;
    logic [`NUM_MOTORS-1:0][31:0]   exp_steps;
    resetn         = 1'b1;
    word_received  = 1'b0;
    word_data.data = '0;
    expected_dir   = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);

    check_value("step", 64'(step), 64'd0);
    check_value("enable", 64'(enable), 64'd0);
    check_value("brake", 64'(brake), 64'd0);
    check_value("move_done", 64'(move_done), 64'd0);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    check_value("word_send_data", word_send_data, 64'd0);

    send_word(make_header(CMD_API_VERSION, 48'd0), reply);
    check_value("word_send_data", reply,
                {32'd0, `VERSION_DEVEL, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH});
    send_word(make_header(CMD_CHANNEL_INFO, 48'd0), reply);
    check_value("word_send_data", reply, {32'd0, 8'(`MOVE_DURATION_BITS), 8'(`DDA_BITS),
                                          8'd0, 8'(`NUM_MOTORS)});
    send_word(make_header(8'h55, 48'hffff), reply);
    check_value("word_send_data", reply, 64'd0);

    pattern = `NUM_MOTORS'($random(seed));
    send_word(make_header(CMD_MOTOR_ENABLE, 48'(pattern)), reply);
    check_value("enable", 64'(enable), 64'(pattern));
    pattern = `NUM_MOTORS'($random(seed));
    send_word(make_header(CMD_MOTOR_BRAKE, 48'(pattern)), reply);
    check_value("brake", 64'(brake), 64'(pattern));

    send_word(make_header(CMD_CLK_DIVISOR, 48'd2), reply);

    // Constant rate move, axis 1 at half the rate of axis 0
    dur                = 32'(4 * (1 + ($random(seed) & 15)));
    axes[0].increment  = 64'h8000_0000_0000_0000;
    axes[0].incr_incr  = '0;
    axes[1].increment  = 64'h4000_0000_0000_0000;
    axes[1].incr_incr  = '0;
    exp_steps[0]       = dur / 2;
    exp_steps[1]       = dur / 4;
    run_move(`NUM_MOTORS'($random(seed)), dur, axes, exp_steps);

    // Accelerating move from standstill
    if (timeout_errors == 0) begin
      dur = 32'(24 + ($random(seed) & 31));
      for (int i = 0; i < `NUM_MOTORS; i++) begin
        axes[i].increment = '0;
        axes[i].incr_incr = 64'h1000_0000_0000_0000;
        exp_steps[i]      = 32'(count_carries(dur, axes[i]));
      end
      run_move(`NUM_MOTORS'($random(seed)), dur, axes, exp_steps);
    end

    if (timeout_errors == 0) fill_buffer_and_drop();

    $display("Errors: value %0d, pulse %0d, timeout %0d",
             value_errors, pulse_errors, timeout_errors);
    if (value_errors + pulse_errors + timeout_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
logic/motion_pkg.sv
logic/command_decoder.sv
logic/move_buffer.sv
logic/dda_sequencer.sv
logic/dda_axis.sv
logic/motion_core_top.sv
tb/tb_motion_core.sv

/* Bender.yml */
package:
  name: motion_core

sources:
  - include_dirs:
      - include
    files:
      - logic/motion_pkg.sv
      - logic/command_decoder.sv
      - logic/move_buffer.sv
      - logic/dda_sequencer.sv
      - logic/dda_axis.sv
      - logic/motion_core_top.sv
      - target: simulation
        files:
          - tb/tb_motion_core.sv
